/* alu_pkg.sv */
// execute unit shared types: opcodes, instruction formats, flags and stage payloads
`default_nettype none

package alu_pkg;

   typedef enum logic [3:0] {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_nand = 4'd2,
      op_xor  = 4'd3,
      op_inc  = 4'd4,
      op_sra  = 4'd5,
      op_srl  = 4'd6,
      op_sll  = 4'd7,
      op_ldi  = 4'd8   // 9..15 illegal
   } opcode_t;

   typedef struct packed {
      opcode_t    op;
      logic [3:0] rd;
      logic [3:0] rs;
      logic [3:0] rt;   // shift amount on shifts
   } r_fmt_t;

   typedef struct packed {
      opcode_t           op;
      logic [3:0]        rd;
      logic signed [7:0] imm;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_t;

   typedef struct packed {
      logic z;
      logic v;
      logic n;
   } flags_t;

   typedef struct packed {
      opcode_t     op;
      logic [3:0]  rd;
      logic [15:0] a;
      logic [15:0] b;
      logic [3:0]  shamt;
      logic        wr;   // write back result
   } opnd_t;

   typedef struct packed {
      logic [3:0]  rd;
      logic        wr;
      logic [15:0] value;
      flags_t      new_flags;
      flags_t      flag_mask;   // set bit = update that flag
      logic [12:0] pad;
   } res_t;

endpackage

`default_nettype wire

/* exec_ctrl.sv */
// execute unit control FSM: accepts an instruction and sequences the operand and result stages
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic instr_valid,
   output logic busy,
   output logic op_load,
   output logic res_load
);

   typedef enum logic [1:0] {
      st_idle,
      st_execute,
      st_retire
   } state_t;

   state_t state;
   state_t state_nxt;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle:    if (instr_valid) state_nxt = st_execute;
         st_execute: state_nxt = st_retire;   // alu cycle
         st_retire:  state_nxt = st_idle;     // done cycle
         default:    state_nxt = st_idle;
      endcase
   end

   assign busy     = (state != st_idle);
   assign op_load  = instr_valid && (state == st_idle);   // operands taken at the accept edge
   assign res_load = (state == st_execute);

   // one instruction in flight, the source must hold off while busy
   a_no_valid_when_busy: assert property (
      @(posedge clk) disable iff (rst) instr_valid |-> !busy
   ) else $error("exec_ctrl: instr_valid while busy");

endmodule

`default_nettype wire

/* reg_file.sv */
// sixteen 16-bit registers, two combinational read ports, one synchronous write port
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic        clk,
   input  logic        rst,
   input  logic [3:0]  raddr_a,
   input  logic [3:0]  raddr_b,
   output logic [15:0] rdata_a,
   output logic [15:0] rdata_b,
   input  logic        we,
   input  logic [3:0]  waddr,
   input  logic [15:0] wdata
);

   logic [15:0] regs [16];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // no bypass, the previous instruction has retired before the next read
   assign rdata_a = regs[raddr_a];
   assign rdata_b = regs[raddr_b];

   a_waddr_known: assert property (
      @(posedge clk) disable iff (rst) we |-> !$isunknown(waddr)
   ) else $error("reg_file: write with unknown address");

endmodule

`default_nettype wire

/* operand_sel.sv */
// operand stage: decodes the instruction form, picks register or immediate operands
`timescale 1ns/1ps
`default_nettype none

module operand_sel import alu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        op_load,
   input  instr_t      instr,
   output logic [3:0]  raddr_a,
   output logic [3:0]  raddr_b,
   input  logic [15:0] rdata_a,
   input  logic [15:0] rdata_b,
   output opnd_t       opnd
);

   opnd_t       opnd_nxt;
   logic [15:0] imm_ext;

   assign imm_ext = {{8{instr.i.imm[7]}}, instr.i.imm};   // sign extend
   assign raddr_a = (instr.r.op == op_inc) ? instr.i.rd : instr.r.rs;   // inc reads its own rd
   assign raddr_b = instr.r.rt;

   always_comb begin
      opnd_nxt       = '0;
      opnd_nxt.op    = instr.r.op;
      opnd_nxt.rd    = instr.r.rd;
      opnd_nxt.a     = rdata_a;
      opnd_nxt.b     = rdata_b;
      opnd_nxt.shamt = instr.r.rt;
      opnd_nxt.wr    = 1'b1;
      case (instr.r.op)
         op_add, op_sub, op_nand, op_xor, op_sra, op_srl, op_sll: ;
         op_inc:  opnd_nxt.b = imm_ext;
         op_ldi: begin
            opnd_nxt.a = '0;
            opnd_nxt.b = imm_ext;
         end
         default: opnd_nxt.wr = 1'b0;   // illegal, no write back
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         opnd <= '0;
      end else if (op_load) begin
         opnd <= opnd_nxt;
      end
   end

endmodule

`default_nettype wire

/* alu_core.sv */
// combinational 16-bit signed ALU with Z, V, N flags and a per-flag update mask
`timescale 1ns/1ps
`default_nettype none

module alu_core import alu_pkg::*; (
   input  opnd_t opnd,
   output res_t  res
);

   logic [15:0] sum;
   logic [15:0] diff;
   logic        add_ovf;
   logic        sub_ovf;

   assign sum  = opnd.a + opnd.b;
   assign diff = opnd.a - opnd.b;

   // same sign in, other sign out
   assign add_ovf = (opnd.a[15] == opnd.b[15]) && (sum[15] != opnd.a[15]);
   // signs differ and result flips away from a
   assign sub_ovf = (opnd.a[15] != opnd.b[15]) && (diff[15] != opnd.a[15]);

   always_comb begin
      res    = '0;
      res.rd = opnd.rd;
      res.wr = opnd.wr;

      case (opnd.op)
         op_add, op_inc: begin
            res.value       = sum;
            res.new_flags.v = add_ovf;
            res.flag_mask   = '1;
         end
         op_sub: begin
            res.value       = diff;
            res.new_flags.v = sub_ovf;
            res.flag_mask   = '1;
         end
         op_nand: begin
            res.value     = ~(opnd.a & opnd.b);
            res.flag_mask = '1;   // v stays cleared
         end
         op_xor: begin
            res.value     = opnd.a ^ opnd.b;
            res.flag_mask = '1;
         end
         op_sra: begin
            res.value = $signed(opnd.a) >>> opnd.shamt;   // keeps sign bit
         end
         op_srl: begin
            res.value = opnd.a >> opnd.shamt;
         end
         op_sll: begin
            res.value = opnd.a << opnd.shamt;
         end
         op_ldi: begin
            res.value = opnd.b;
         end
         default: begin
            res.value = '0;   // illegal, mask stays empty
         end
      endcase

      res.new_flags.z = (res.value == 16'd0);
      res.new_flags.n = res.value[15];
   end

endmodule

`default_nettype wire

/* result_stage.sv */
// result stage: result and flag registers, register file write port and done pulse
`timescale 1ns/1ps
`default_nettype none

module result_stage import alu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        res_load,
   input  res_t        res,
   output logic        we,
   output logic [3:0]  waddr,
   output logic [15:0] wdata,
   output logic [15:0] result,
   output flags_t      flags,
   output logic        done
);

   // write lands in the register file on the same edge as the result
   assign we    = res_load && res.wr;
   assign waddr = res.rd;
   assign wdata = res.value;

   always_ff @(posedge clk) begin
      if (rst) begin
         result <= '0;
         flags  <= '0;
         done   <= 1'b0;
      end else begin
         done <= res_load;
         if (res_load) begin
            result <= res.value;
            flags  <= (flags & ~res.flag_mask) | (res.new_flags & res.flag_mask);   // masked update
         end
      end
   end

   // single-cycle pulse, instructions are spaced by the control FSM
   a_done_single: assert property (
      @(posedge clk) disable iff (rst) done |=> !done
   ) else $error("result_stage: done high two cycles in a row");

endmodule

`default_nettype wire

/* exec_top.sv */
// execute unit top: control FSM, register file, operand stage, ALU and result stage
`timescale 1ns/1ps
`default_nettype none

module exec_top import alu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        instr_valid,
   input  instr_t      instr,
   output logic        busy,
   output logic        done,
   output logic [15:0] result,
   output flags_t      flags
);

   logic        op_load;
   logic        res_load;
   logic [3:0]  raddr_a;
   logic [3:0]  raddr_b;
   logic [15:0] rdata_a;
   logic [15:0] rdata_b;
   logic        we;
   logic [3:0]  waddr;
   logic [15:0] wdata;
   opnd_t       opnd;
   res_t        res;

   exec_ctrl ctrl_i (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .busy        (busy),
      .op_load     (op_load),
      .res_load    (res_load)
   );

   reg_file rf_i (
      .clk     (clk),
      .rst     (rst),
      .raddr_a (raddr_a),
      .raddr_b (raddr_b),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b),
      .we      (we),
      .waddr   (waddr),
      .wdata   (wdata)
   );

   operand_sel opsel_i (
      .clk     (clk),
      .rst     (rst),
      .op_load (op_load),
      .instr   (instr),
      .raddr_a (raddr_a),
      .raddr_b (raddr_b),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b),
      .opnd    (opnd)
   );

   alu_core alu_i (
      .opnd (opnd),
      .res  (res)
   );

   result_stage rstage_i (
      .clk      (clk),
      .rst      (rst),
      .res_load (res_load),
      .res      (res),
      .we       (we),
      .waddr    (waddr),
      .wdata    (wdata),
      .result   (result),
      .flags    (flags),
      .done     (done)
   );

endmodule

`default_nettype wire

/* tb_exec_top.sv */
// testbench for the execute unit: LFSR stimulus, reference model and result checks
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top import alu_pkg::*; ();

   localparam int max_cycles = 1500;   // 326 instructions at 3 cycles plus reset and margin

   logic        clk;
   logic        rst;
   logic        instr_valid;
   instr_t      instr;
   logic        busy;
   logic        done;
   logic [15:0] result;
   flags_t      flags;

   logic [31:0] lfsr;
   logic [15:0] m_regs [16];   // model register file
   flags_t      m_flags;
   int          cycle_count;
   int          check_count;
   int          value_errors;
   int          timing_errors;

   exec_top dut_i (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .busy        (busy),
      .done        (done),
      .result      (result),
      .flags       (flags)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < max_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
   end

   // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic instr_t make_r(input logic [3:0] op, input logic [3:0] rd,
                                     input logic [3:0] rs, input logic [3:0] rt);
      instr_t w;
      w = {op, rd, rs, rt};
      return w;
   endfunction

   function automatic instr_t make_i(input logic [3:0] op, input logic [3:0] rd,
                                     input logic [7:0] imm);
      instr_t w;
      w = {op, rd, imm};
      return w;
   endfunction

   task automatic compare_value(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
      check_count++;
      assert (got === exp) else begin
         value_errors++;
         $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_timing(input logic ok, input string what);
      check_count++;
      assert (ok) else begin
         timing_errors++;
         $display("timing error at %0d ns: %s", $time, what);
      end
   endtask

   // one instruction applied to the model registers and flags
   task automatic apply_model(input instr_t ins, output logic [15:0] val, output logic keeps);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm_x;
      logic [16:0] wide;   // sign-extended sum for overflow
      logic [31:0] ext;
      logic        upd;
      logic        wr;
      imm_x = {{8{ins.i.imm[7]}}, ins.i.imm};
      a     = m_regs[ins.r.rs];
      b     = m_regs[ins.r.rt];
      wide  = '0;
      val   = '0;
      upd   = 1'b1;
      wr    = 1'b1;
      case (ins.r.op)
         op_add: begin
            wide = {a[15], a} + {b[15], b};
            val  = wide[15:0];
         end
         op_sub: begin
            wide = {a[15], a} - {b[15], b};
            val  = wide[15:0];
         end
         op_inc: begin
            wide = {m_regs[ins.r.rd][15], m_regs[ins.r.rd]} + {imm_x[15], imm_x};
            val  = wide[15:0];
         end
         op_nand: val = ~(a & b);
         op_xor:  val = a ^ b;
         op_sra: begin
            ext = {{16{a[15]}}, a} >> ins.r.rt;
            val = ext[15:0];
            upd = 1'b0;
         end
         op_srl: begin
            val = a >> ins.r.rt;
            upd = 1'b0;
         end
         op_sll: begin
            val = a << ins.r.rt;
            upd = 1'b0;
         end
         op_ldi: begin
            val = imm_x;
            upd = 1'b0;
         end
         default: begin
            upd = 1'b0;   // illegal opcode
            wr  = 1'b0;
         end
      endcase
      if (upd) begin
         m_flags.z = (val == 16'd0);
         m_flags.v = wide[16] ^ wide[15];
         m_flags.n = val[15];
      end
      if (wr) m_regs[ins.r.rd] = val;
      keeps = !upd;
   endtask

   task automatic run_instr(input instr_t ins);
      logic [15:0] exp_val;
      logic        keeps;
      flags_t      flags_before;
      int          waited;
      instr        = ins;   // entered 1 ns after a rising edge
      instr_valid  = 1'b1;
      flags_before = flags;
      @(posedge clk);   // accept edge
      #1;
      instr_valid = 1'b0;
      apply_model(ins, exp_val, keeps);
      waited = 0;
      @(negedge clk);
      check_timing(busy, "busy low while an instruction is in flight");
      while (!done) begin
         waited++;
         @(negedge clk);
      end
      check_timing(waited == 1, "done did not rise one cycle after the instruction was accepted");
      compare_value("result", result, exp_val);
      compare_value("flags", {13'd0, flags}, {13'd0, m_flags});
      if (keeps) begin
         compare_value("flags kept", {13'd0, flags}, {13'd0, flags_before});
      end
      @(posedge clk);   // done falls, next instruction may follow
      #1;
      check_timing(!done, "done stayed high for more than one cycle");
      check_timing(!busy, "busy still high in the cycle after done");
   endtask

   initial begin
      instr_t      w;
      logic [31:0] rnd;
      rst           = 1'b1;
      instr_valid   = 1'b0;
      instr         = '0;
      lfsr          = 32'hc37f_2747;
      check_count   = 0;
      value_errors  = 0;
      timing_errors = 0;
      m_flags       = '0;
      for (int r = 0; r < 16; r++) m_regs[r] = '0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      repeat (3) begin   // idle unit stays quiet
         @(negedge clk);
         check_timing(!busy && !done, "busy or done high with no instruction issued");
      end
      @(posedge clk);
      #1;
      run_instr(make_r(op_add, 4'd0, 4'd0, 4'd0));
      compare_value("result after reset", result, 16'd0);
      compare_value("flags.z after reset", {15'd0, flags.z}, 16'd1);

      // operands at the signed limits
      run_instr(make_i(op_ldi, 4'd1, 8'h01));
      run_instr(make_r(op_sll, 4'd2, 4'd1, 4'd15));   // 0x8000
      run_instr(make_i(op_ldi, 4'd3, 8'hff));
      run_instr(make_r(op_srl, 4'd4, 4'd3, 4'd1));    // 0x7fff
      run_instr(make_r(op_add, 4'd5, 4'd4, 4'd4));
      run_instr(make_r(op_sub, 4'd6, 4'd2, 4'd4));
      run_instr(make_r(op_add, 4'd7, 4'd2, 4'd2));    // zero with overflow
      run_instr(make_i(op_inc, 4'd4, 8'h01));
      run_instr(make_r(op_sra, 4'd8, 4'd2, 4'd3));

      for (int i = 0; i < 300; i++) begin
         if (i < 60) begin   // fill phase
            rnd = rand_bits(8);
            w   = make_i(op_ldi, i[3:0], rnd[7:0]);
         end else begin
            rnd = rand_bits(16);
            w   = rnd[15:0];
         end
         run_instr(w);
      end

      // every register seen through add with r0
      for (int x = 15; x >= 0; x--) begin
         run_instr(make_r(op_add, x[3:0], x[3:0], 4'd0));
      end

      $display("checks: %0d, value errors: %0d, timing errors: %0d",
               check_count, value_errors, timing_errors);
      if (value_errors == 0 && timing_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
alu_pkg.sv
exec_ctrl.sv
reg_file.sv
operand_sel.sv
alu_core.sv
result_stage.sv
exec_top.sv
tb_exec_top.sv

/* run.sh */
#!/bin/sh
# compile and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_exec_top \
   --Mdir obj_dir -o sim_exec
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/sim_exec)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
